// File: design/lsu_pkg.sv
package lsu_pkg;

   //************************************************************
   // Widths
   //************************************************************
   localparam int ADDR_W   = 32;
   localparam int DATA_W   = 32;
   localparam int SD_W     = 64;
   localparam int OFFSET_W = 12;

   //************************************************************
   // Memory map
   //************************************************************
   localparam int DCCM_WIN_BITS = 16;
   localparam int PIC_WIN_BITS  = 15;
   localparam int REGION_BITS   = 4;

   localparam logic [ADDR_W-1:0] DCCM_BASE_RST = 32'hF004_0000;
   localparam logic [ADDR_W-1:0] PIC_BASE_RST  = 32'hF00C_0000;
   // One bit per 256 MB region, upper half of the map is side-effect
   localparam logic [2**REGION_BITS-1:0] SIDE_EFFECT_RST = 16'hFF00;

   // Configuration selectors
   localparam logic [1:0] CFG_DCCM_BASE   = 2'd0;
   localparam logic [1:0] CFG_PIC_BASE    = 2'd1;
   localparam logic [1:0] CFG_SIDE_EFFECT = 2'd2;

   //************************************************************
   // Packets
   //************************************************************
   typedef struct packed {
      logic valid;
      logic dma;
      logic load;
      logic store;
      logic unsign;
      logic by;
      logic half;
      logic word;
      logic dword;
   } lsu_pkt_t;

   typedef struct packed {
      logic              valid;
      logic [1:0]        sel;
      logic [DATA_W-1:0] data;
   } lsu_cfg_wr_t;

   typedef struct packed {
      logic [ADDR_W-1:0]          dccm_base;
      logic [ADDR_W-1:0]          pic_base;
      logic [2**REGION_BITS-1:0]  side_effect;
   } lsu_region_t;

   typedef struct packed {
      logic dc2_up;
      logic dc3;
      logic dc4;
      logic dc5;
   } lsu_flush_t;

   // Payload of DC1 to DC3
   typedef struct packed {
      lsu_pkt_t          pkt;
      logic [ADDR_W-1:0] addr;
      logic [ADDR_W-1:0] end_addr;
      logic [SD_W-1:0]   store_data;
      logic              in_dccm;
      logic              in_pic;
      logic              external;
      logic              access_fault;
      logic              misaligned_fault;
      logic              side_effect;
   } lsu_early_t;

   // Payload of DC4 and DC5
   typedef struct packed {
      lsu_pkt_t          pkt;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] store_data;
      logic              external;
   } lsu_late_t;

   typedef struct packed {
      logic              exc_valid;
      logic              inst_type;
      logic              exc_type;
      logic              dma_valid;
      logic [ADDR_W-1:0] addr;
   } lsu_error_pkt_t;

endpackage

// File: design/lsu_region_cfg.sv
module lsu_region_cfg (
   input  logic                 clk,
   input  logic                 rst,
   input  lsu_pkg::lsu_cfg_wr_t cfg_wr,
   output lsu_pkg::lsu_region_t region
);
   import lsu_pkg::*;

   // Bases keep only the bits above their window
   always_ff @(posedge clk) begin
      if (rst) begin
         region.dccm_base   <= DCCM_BASE_RST;
         region.pic_base    <= PIC_BASE_RST;
         region.side_effect <= SIDE_EFFECT_RST;
      end else if (cfg_wr.valid) begin
         case (cfg_wr.sel)
            CFG_DCCM_BASE: begin
               region.dccm_base <= {cfg_wr.data[ADDR_W-1:DCCM_WIN_BITS], {DCCM_WIN_BITS{1'b0}}};
            end
            CFG_PIC_BASE: begin
               region.pic_base <= {cfg_wr.data[ADDR_W-1:PIC_WIN_BITS], {PIC_WIN_BITS{1'b0}}};
            end
            CFG_SIDE_EFFECT: begin
               region.side_effect <= cfg_wr.data[2**REGION_BITS-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   // PIC window must sit outside the larger DCCM window
   a_no_overlap: assert property (@(posedge clk) disable iff (rst)
      region.dccm_base[ADDR_W-1:DCCM_WIN_BITS] != region.pic_base[ADDR_W-1:DCCM_WIN_BITS])
      else $error("DCCM and PIC windows overlap");

endmodule

// File: design/lsu_req_mux.sv
module lsu_req_mux (
   input  logic                              clk,
   input  logic                              rst,
   input  lsu_pkg::lsu_pkt_t                 lsu_p,
   input  logic [lsu_pkg::ADDR_W-1:0]        exu_lsu_rs1_d,
   input  logic [lsu_pkg::DATA_W-1:0]        exu_lsu_rs2_d,
   input  logic [lsu_pkg::OFFSET_W-1:0]      dec_lsu_offset_d,
   input  logic                              dma_dccm_req,
   input  logic [lsu_pkg::ADDR_W-1:0]        dma_mem_addr,
   input  logic [2:0]                        dma_mem_sz,
   input  logic                              dma_mem_write,
   input  logic [lsu_pkg::SD_W-1:0]          dma_mem_wdata,
   input  logic                              flush_dc2_up,
   output lsu_pkg::lsu_pkt_t                 pkt_dc1,
   output logic [lsu_pkg::ADDR_W-1:0]        rs1_dc1,
   output logic [lsu_pkg::OFFSET_W-1:0]      offset_dc1,
   output logic [lsu_pkg::SD_W-1:0]          store_data_dc1
);
   import lsu_pkg::*;

   lsu_pkt_t            dma_pkt;
   lsu_pkt_t            pkt_d;
   logic [SD_W-1:0]     dma_wdata_shifted;

   always_comb begin
      dma_pkt        = '0;
      dma_pkt.valid  = dma_dccm_req;
      dma_pkt.dma    = 1'b1;
      dma_pkt.store  = dma_mem_write;
      dma_pkt.load   = ~dma_mem_write;
      dma_pkt.by     = (dma_mem_sz == 3'd0);
      dma_pkt.half   = (dma_mem_sz == 3'd1);
      dma_pkt.word   = (dma_mem_sz == 3'd2);
      dma_pkt.dword  = (dma_mem_sz == 3'd3);

      // DMA wins, a flushed core request never enters DC1
      pkt_d       = dma_dccm_req ? dma_pkt : lsu_p;
      pkt_d.valid = (lsu_p.valid & ~flush_dc2_up) | dma_dccm_req;
   end

   // Line DMA data up with the byte lanes of a core store
   assign dma_wdata_shifted = dma_mem_wdata >> {dma_mem_addr[2:0], 3'b000};

   always_ff @(posedge clk) begin
      pkt_dc1        <= pkt_d;
      rs1_dc1        <= dma_dccm_req ? dma_mem_addr : exu_lsu_rs1_d;
      offset_dc1     <= dma_dccm_req ? '0 : dec_lsu_offset_d;
      store_data_dc1 <= dma_dccm_req ? dma_wdata_shifted : SD_W'(exu_lsu_rs2_d);
      if (rst) begin
         pkt_dc1.valid <= 1'b0;
      end
   end

endmodule

// File: design/lsu_addr_check.sv
module lsu_addr_check (
   input  lsu_pkg::lsu_pkt_t             pkt_dc1,
   input  logic [lsu_pkg::ADDR_W-1:0]    rs1_dc1,
   input  logic [lsu_pkg::OFFSET_W-1:0]  offset_dc1,
   input  logic [lsu_pkg::SD_W-1:0]      store_data_dc1,
   input  lsu_pkg::lsu_region_t          region,
   output lsu_pkg::lsu_early_t           early_dc1
);
   import lsu_pkg::*;

   logic [ADDR_W-1:0] start_addr;
   logic [ADDR_W-1:0] end_addr;
   logic [2:0]        size_inc;
   logic              start_in_dccm;
   logic              end_in_dccm;
   logic              start_in_pic;
   logic              unaligned;
   logic              region_cross;
   logic              side_effect;

   // Last byte offset: 0, 1, 3 or 7
   assign size_inc = {pkt_dc1.dword,
                      pkt_dc1.word | pkt_dc1.dword,
                      pkt_dc1.half | pkt_dc1.word | pkt_dc1.dword};

   assign start_addr = rs1_dc1 + {{(ADDR_W-OFFSET_W){offset_dc1[OFFSET_W-1]}}, offset_dc1};
   assign end_addr   = start_addr + ADDR_W'(size_inc);

   //************************************************************
   // Region decode
   //************************************************************
   assign start_in_dccm = start_addr[ADDR_W-1:DCCM_WIN_BITS] ==
                          region.dccm_base[ADDR_W-1:DCCM_WIN_BITS];
   assign end_in_dccm   = end_addr[ADDR_W-1:DCCM_WIN_BITS] ==
                          region.dccm_base[ADDR_W-1:DCCM_WIN_BITS];
   assign start_in_pic  = start_addr[ADDR_W-1:PIC_WIN_BITS] ==
                          region.pic_base[ADDR_W-1:PIC_WIN_BITS];

   assign side_effect  = region.side_effect[start_addr[ADDR_W-1 -: REGION_BITS]];
   assign region_cross = start_addr[ADDR_W-1 -: REGION_BITS] != end_addr[ADDR_W-1 -: REGION_BITS];

   assign unaligned = (pkt_dc1.half  & start_addr[0]) |
                      (pkt_dc1.word  & (|start_addr[1:0])) |
                      (pkt_dc1.dword & (|start_addr[2:0]));

   always_comb begin
      early_dc1.pkt              = pkt_dc1;
      early_dc1.addr             = start_addr;
      early_dc1.end_addr         = end_addr;
      early_dc1.store_data       = store_data_dc1;
      early_dc1.in_dccm          = start_in_dccm;
      early_dc1.in_pic           = start_in_pic;
      early_dc1.external         = ~(start_in_dccm | start_in_pic);
      early_dc1.side_effect      = side_effect;
      early_dc1.misaligned_fault = unaligned & (side_effect | region_cross);
      // Access straddling the DCCM edge, or PIC not a word
      early_dc1.access_fault     = (start_in_dccm ^ end_in_dccm) |
                                   (start_in_pic & ~pkt_dc1.word);
   end

   // Holds only while the configured windows stay apart
   always_comb begin
      if (pkt_dc1.valid) begin
         a_one_window: assert (!(start_in_dccm && start_in_pic))
            else $error("Address decoded into both DCCM and PIC");
      end
   end

endmodule

// File: design/lsu_pipe_stage.sv
module lsu_pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     valid_in,
   input  logic     kill,
   input  payload_t data_in,
   output logic     valid_out,
   output payload_t data_out
);

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_out <= 1'b0;
      end else begin
         valid_out <= valid_in & ~kill;
      end
   end

   // Payload follows every cycle, the valid qualifies it
   always_ff @(posedge clk) begin
      data_out <= data_in;
   end

   a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(valid_out))
      else $error("Stage valid is unknown");

endmodule

// File: design/lsu_dc_pipe.sv
module lsu_dc_pipe (
   input  logic                          clk,
   input  logic                          rst,
   input  lsu_pkg::lsu_early_t           early_dc1,
   input  lsu_pkg::lsu_flush_t           flush,
   output lsu_pkg::lsu_early_t           early_dc3,
   output lsu_pkg::lsu_pkt_t             lsu_pkt_dc3,
   output logic [lsu_pkg::ADDR_W-1:0]    lsu_addr_dc3,
   output lsu_pkg::lsu_error_pkt_t       lsu_error_pkt_dc3,
   output lsu_pkg::lsu_pkt_t             lsu_pkt_dc5,
   output logic [lsu_pkg::ADDR_W-1:0]    lsu_addr_dc5,
   output logic [lsu_pkg::DATA_W-1:0]    store_data_dc5,
   output logic                          addr_external_dc5,
   output logic                          lsu_commit_dc5
);
   import lsu_pkg::*;

   lsu_early_t early_dc2_q;
   lsu_early_t early_dc2;
   lsu_early_t early_dc3_q;
   lsu_late_t  late_dc4_in;
   lsu_late_t  late_dc4_q;
   lsu_late_t  late_dc5_q;
   lsu_late_t  late_dc5;
   logic       valid_dc2;
   logic       valid_dc3;
   logic       valid_dc4;
   logic       valid_dc5;
   logic       kill_dc1;
   logic       kill_dc2;
   logic       kill_dc3;
   logic       kill_dc4;

   // Flushes drop core requests only
   assign kill_dc1 = flush.dc2_up & ~early_dc1.pkt.dma;
   assign kill_dc2 = flush.dc2_up & ~early_dc2.pkt.dma;
   assign kill_dc3 = flush.dc3    & ~early_dc3.pkt.dma;
   assign kill_dc4 = flush.dc4    & ~late_dc4_q.pkt.dma;

   lsu_pipe_stage #(.payload_t(lsu_early_t)) dc2_stage (
      .clk(clk), .rst(rst), .valid_in(early_dc1.pkt.valid), .kill(kill_dc1),
      .data_in(early_dc1), .valid_out(valid_dc2), .data_out(early_dc2_q));

   lsu_pipe_stage #(.payload_t(lsu_early_t)) dc3_stage (
      .clk(clk), .rst(rst), .valid_in(valid_dc2), .kill(kill_dc2),
      .data_in(early_dc2), .valid_out(valid_dc3), .data_out(early_dc3_q));

   lsu_pipe_stage #(.payload_t(lsu_late_t)) dc4_stage (
      .clk(clk), .rst(rst), .valid_in(valid_dc3), .kill(kill_dc3),
      .data_in(late_dc4_in), .valid_out(valid_dc4), .data_out(late_dc4_q));

   lsu_pipe_stage #(.payload_t(lsu_late_t)) dc5_stage (
      .clk(clk), .rst(rst), .valid_in(valid_dc4), .kill(kill_dc4),
      .data_in(late_dc4_q), .valid_out(valid_dc5), .data_out(late_dc5_q));

   always_comb begin
      early_dc2           = early_dc2_q;
      early_dc2.pkt.valid = valid_dc2;
      early_dc3           = early_dc3_q;
      early_dc3.pkt.valid = valid_dc3;
      late_dc5            = late_dc5_q;
      late_dc5.pkt.valid  = valid_dc5;

      // Store data narrows to one word past DC3
      late_dc4_in.pkt        = early_dc3.pkt;
      late_dc4_in.addr       = early_dc3.addr;
      late_dc4_in.store_data = early_dc3.store_data[DATA_W-1:0];
      late_dc4_in.external   = early_dc3.external;
   end

   //************************************************************
   // DC3 error report
   //************************************************************
   assign lsu_error_pkt_dc3.exc_valid = (early_dc3.access_fault | early_dc3.misaligned_fault) &
                                        valid_dc3 & ~early_dc3.pkt.dma & ~flush.dc3;
   assign lsu_error_pkt_dc3.inst_type = early_dc3.pkt.store;
   assign lsu_error_pkt_dc3.exc_type  = ~early_dc3.misaligned_fault;
   assign lsu_error_pkt_dc3.dma_valid = early_dc3.pkt.dma;
   assign lsu_error_pkt_dc3.addr      = early_dc3.addr;

   assign lsu_pkt_dc3  = early_dc3.pkt;
   assign lsu_addr_dc3 = early_dc3.addr;

   assign lsu_pkt_dc5       = late_dc5.pkt;
   assign lsu_addr_dc5      = late_dc5.addr;
   assign store_data_dc5    = late_dc5.store_data;
   assign addr_external_dc5 = late_dc5.external;
   assign lsu_commit_dc5    = valid_dc5 & (late_dc5.pkt.load | late_dc5.pkt.store) &
                              ~late_dc5.pkt.dma & ~flush.dc5;

endmodule

// File: design/lsu_load_format.sv
module lsu_load_format (
   input  lsu_pkg::lsu_early_t          early_dc3,
   input  logic [lsu_pkg::DATA_W-1:0]   lsu_ld_data_dc3,
   input  logic [lsu_pkg::DATA_W-1:0]   bus_read_data_dc3,
   output logic [lsu_pkg::DATA_W-1:0]   lsu_result_dc3
);
   import lsu_pkg::*;

   logic [DATA_W-1:0] ld_data;

   // External loads come back over the bus, the rest from DCCM
   assign ld_data = early_dc3.external ? bus_read_data_dc3 : lsu_ld_data_dc3;

   always_comb begin
      if (early_dc3.pkt.by) begin
         lsu_result_dc3 = early_dc3.pkt.unsign ? {24'b0, ld_data[7:0]} :
                                                 {{24{ld_data[7]}}, ld_data[7:0]};
      end else if (early_dc3.pkt.half) begin
         lsu_result_dc3 = early_dc3.pkt.unsign ? {16'b0, ld_data[15:0]} :
                                                 {{16{ld_data[15]}}, ld_data[15:0]};
      end else begin
         // Word and double-word, low word only
         lsu_result_dc3 = ld_data;
      end
   end

endmodule

// File: design/lsu_ctl_top.sv
module lsu_ctl_top (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [lsu_pkg::ADDR_W-1:0]    exu_lsu_rs1_d,
   input  logic [lsu_pkg::DATA_W-1:0]    exu_lsu_rs2_d,
   input  logic [lsu_pkg::OFFSET_W-1:0]  dec_lsu_offset_d,
   input  lsu_pkg::lsu_pkt_t             lsu_p,
   input  logic                          dma_dccm_req,
   input  logic [lsu_pkg::ADDR_W-1:0]    dma_mem_addr,
   input  logic [2:0]                    dma_mem_sz,
   input  logic                          dma_mem_write,
   input  logic [lsu_pkg::SD_W-1:0]      dma_mem_wdata,
   input  lsu_pkg::lsu_flush_t           flush,
   input  lsu_pkg::lsu_cfg_wr_t          cfg_wr,
   input  logic [lsu_pkg::DATA_W-1:0]    lsu_ld_data_dc3,
   input  logic [lsu_pkg::DATA_W-1:0]    bus_read_data_dc3,
   output lsu_pkg::lsu_pkt_t             lsu_pkt_dc3,
   output logic [lsu_pkg::ADDR_W-1:0]    lsu_addr_dc3,
   output logic [lsu_pkg::DATA_W-1:0]    lsu_result_dc3,
   output lsu_pkg::lsu_error_pkt_t       lsu_error_pkt_dc3,
   output lsu_pkg::lsu_pkt_t             lsu_pkt_dc5,
   output logic [lsu_pkg::ADDR_W-1:0]    lsu_addr_dc5,
   output logic [lsu_pkg::DATA_W-1:0]    store_data_dc5,
   output logic                          addr_external_dc5,
   output logic                          lsu_commit_dc5
);
   import lsu_pkg::*;

   lsu_region_t         region;
   lsu_pkt_t            pkt_dc1;
   logic [ADDR_W-1:0]   rs1_dc1;
   logic [OFFSET_W-1:0] offset_dc1;
   logic [SD_W-1:0]     store_data_dc1;
   lsu_early_t          early_dc1;
   lsu_early_t          early_dc3;

   lsu_region_cfg region_cfg (.clk(clk), .rst(rst), .cfg_wr(cfg_wr), .region(region));

   lsu_req_mux req_mux (
      .clk(clk), .rst(rst), .lsu_p(lsu_p), .exu_lsu_rs1_d(exu_lsu_rs1_d),
      .exu_lsu_rs2_d(exu_lsu_rs2_d), .dec_lsu_offset_d(dec_lsu_offset_d),
      .dma_dccm_req(dma_dccm_req), .dma_mem_addr(dma_mem_addr), .dma_mem_sz(dma_mem_sz),
      .dma_mem_write(dma_mem_write), .dma_mem_wdata(dma_mem_wdata),
      .flush_dc2_up(flush.dc2_up), .pkt_dc1(pkt_dc1), .rs1_dc1(rs1_dc1),
      .offset_dc1(offset_dc1), .store_data_dc1(store_data_dc1));

   lsu_addr_check addr_check (
      .pkt_dc1(pkt_dc1), .rs1_dc1(rs1_dc1), .offset_dc1(offset_dc1),
      .store_data_dc1(store_data_dc1), .region(region), .early_dc1(early_dc1));

   lsu_dc_pipe dc_pipe (
      .clk(clk), .rst(rst), .early_dc1(early_dc1), .flush(flush), .early_dc3(early_dc3),
      .lsu_pkt_dc3(lsu_pkt_dc3), .lsu_addr_dc3(lsu_addr_dc3),
      .lsu_error_pkt_dc3(lsu_error_pkt_dc3), .lsu_pkt_dc5(lsu_pkt_dc5),
      .lsu_addr_dc5(lsu_addr_dc5), .store_data_dc5(store_data_dc5),
      .addr_external_dc5(addr_external_dc5), .lsu_commit_dc5(lsu_commit_dc5));

   lsu_load_format load_format (
      .early_dc3(early_dc3), .lsu_ld_data_dc3(lsu_ld_data_dc3),
      .bus_read_data_dc3(bus_read_data_dc3), .lsu_result_dc3(lsu_result_dc3));

endmodule

// File: tests/tb_lsu_model.svh
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// One entry per presented cycle, index 0 is the newest, index k sits in stage DCk
typedef struct packed {
   logic        alive;
   logic        dma;
   logic        load;
   logic        store;
   logic        unsign;
   logic [1:0]  size;
   logic [31:0] addr;
   logic [63:0] store_data;
   logic        external;
   logic        access_fault;
   logic        misaligned_fault;
} model_req_t;

model_req_t  pipe_q[$];
logic [31:0] m_dccm_base;
logic [31:0] m_pic_base;
logic [15:0] m_side_effect;

task automatic reset_model();
   pipe_q.delete();
   m_dccm_base   = DCCM_BASE_RST;
   m_pic_base    = PIC_BASE_RST;
   m_side_effect = SIDE_EFFECT_RST;
endtask

// Bases drop the bits inside their window
task automatic apply_config_write(input logic [1:0] sel, input logic [31:0] data);
   case (sel)
      CFG_DCCM_BASE: m_dccm_base = data & 32'hFFFF_0000;
      CFG_PIC_BASE: m_pic_base = data & 32'hFFFF_8000;
      CFG_SIDE_EFFECT: m_side_effect = data[15:0];
      default: begin
      end
   endcase
endtask

function automatic model_req_t decode_request(input logic alive, input logic dma,
      input logic load, input logic unsign, input logic [1:0] size,
      input logic [31:0] base, input logic [11:0] offset, input logic [63:0] sdata);
   model_req_t  r;
   logic [31:0] nbytes;
   logic [31:0] last;
   logic        start_dccm;
   logic        last_dccm;
   logic        start_pic;
   logic        side_eff;
   nbytes       = 32'd1 << size;
   r.alive      = alive;
   r.dma        = dma;
   r.load       = load;
   r.store      = ~load;
   r.unsign     = unsign;
   r.size       = size;
   r.addr       = base + 32'($signed(offset));
   r.store_data = sdata;
   last         = r.addr + nbytes - 32'd1;
   start_dccm   = (r.addr >> 16) == (m_dccm_base >> 16);
   last_dccm    = (last >> 16) == (m_dccm_base >> 16);
   start_pic    = (r.addr >> 15) == (m_pic_base >> 15);
   side_eff     = m_side_effect[r.addr[31:28]];
   r.external   = ~start_dccm & ~start_pic;
   r.misaligned_fault = ((r.addr & (nbytes - 32'd1)) != 32'd0) &&
                        (side_eff || (r.addr[31:28] != last[31:28]));
   r.access_fault = (start_dccm != last_dccm) || (start_pic && size != 2'd2);
   return r;
endfunction

// Packet the request should carry down the pipe
function automatic lsu_pkt_t expected_pkt(input model_req_t r);
   lsu_pkt_t p;
   p        = '0;
   p.valid  = r.alive;
   p.dma    = r.dma;
   p.load   = r.load;
   p.store  = r.store;
   p.unsign = r.unsign;
   p.by     = (r.size == 2'd0);
   p.half   = (r.size == 2'd1);
   p.word   = (r.size == 2'd2);
   p.dword  = (r.size == 2'd3);
   return p;
endfunction

function automatic logic [31:0] format_load(input logic [31:0] raw, input logic [1:0] size,
      input logic unsign);
   logic [31:0] low;
   case (size)
      2'd0: begin
         low = raw & 32'h0000_00FF;
         return unsign ? low : (low ^ 32'h0000_0080) - 32'h0000_0080;
      end
      2'd1: begin
         low = raw & 32'h0000_FFFF;
         return unsign ? low : (low ^ 32'h0000_8000) - 32'h0000_8000;
      end
      default: return raw;
   endcase
endfunction

// Load data seen on the two read paths, distinct per address
function automatic logic [31:0] dccm_hash(input logic [31:0] a);
   return (a * 32'h9E37_79B1) ^ 32'h0F0F_5A5A;
endfunction

function automatic logic [31:0] bus_hash(input logic [31:0] a);
   return {a[15:0], a[31:16]} ^ (a * 32'h85EB_CA6B) ^ 32'hC3A5_1E2D;
endfunction

// Core requests die on the flush of the stage they sit in
task automatic apply_flush();
   model_req_t e;
   logic       kill;
   for (int k = 0; k < 5 && k < pipe_q.size(); k++) begin
      e    = pipe_q[k];
      kill = (k <= 2) ? cur_flush.dc2_up : (k == 3) ? cur_flush.dc3 : cur_flush.dc4;
      if (kill && !e.dma) begin
         e.alive   = 1'b0;
         pipe_q[k] = e;
      end
   end
endtask

function automatic int alive_count();
   int n;
   n = 0;
   foreach (pipe_q[i]) begin
      if (pipe_q[i].alive) begin
         n++;
      end
   end
   return n;
endfunction

`endif

// File: tests/tb_lsu_top.sv
module tb_lsu_top;
   timeunit 1ns;
   timeprecision 100ps;
   import lsu_pkg::*;

   logic                clk;
   logic                rst;
   logic [ADDR_W-1:0]   exu_lsu_rs1_d;
   logic [DATA_W-1:0]   exu_lsu_rs2_d;
   logic [OFFSET_W-1:0] dec_lsu_offset_d;
   lsu_pkt_t            lsu_p;
   logic                dma_dccm_req;
   logic [ADDR_W-1:0]   dma_mem_addr;
   logic [2:0]          dma_mem_sz;
   logic                dma_mem_write;
   logic [SD_W-1:0]     dma_mem_wdata;
   lsu_flush_t          flush;
   lsu_cfg_wr_t         cfg_wr;
   logic [DATA_W-1:0]   lsu_ld_data_dc3;
   logic [DATA_W-1:0]   bus_read_data_dc3;
   lsu_pkt_t            lsu_pkt_dc3;
   logic [ADDR_W-1:0]   lsu_addr_dc3;
   logic [DATA_W-1:0]   lsu_result_dc3;
   lsu_error_pkt_t      lsu_error_pkt_dc3;
   lsu_pkt_t            lsu_pkt_dc5;
   logic [ADDR_W-1:0]   lsu_addr_dc5;
   logic [DATA_W-1:0]   store_data_dc5;
   logic                addr_external_dc5;
   logic                lsu_commit_dc5;
   lsu_flush_t          cur_flush;
   int                  errors;
   int                  waited;

   `include "tb_lsu_model.svh"

   lsu_ctl_top dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      #100000;
      $display("Timeout: run did not finish within 100 us");
      $display("Errors found");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      errors++;
      $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
   endtask

   //************************************************************
   // Stimulus
   //************************************************************
   // Bias toward both windows and the 256 MB region edges
   function automatic logic [31:0] pick_address();
      case ($urandom % 5)
         0: return m_dccm_base + ($urandom % 32'h1_0000);
         1: return m_dccm_base + 32'h0000_FFF8 + ($urandom % 16);
         2: return m_pic_base + ($urandom % 32'h8000);
         3: return {4'($urandom), 28'hFFF_FFF8} + ($urandom % 16);
         default: return $urandom;
      endcase
   endfunction

   // Candidate bases keep the two windows apart
   function automatic logic [31:0] pick_config_data(input logic [1:0] sel);
      logic [31:0] v;
      v = $urandom;
      if (sel == CFG_DCCM_BASE) begin
         case ($urandom % 3)
            0: v = 32'hF004_0000 | (v & 32'h0000_FFFF);
            1: v = 32'h8000_0000 | (v & 32'h0000_FFFF);
            default: v = 32'h2001_0000 | (v & 32'h0000_FFFF);
         endcase
      end else if (sel == CFG_PIC_BASE) begin
         case ($urandom % 3)
            0: v = 32'hF00C_0000 | (v & 32'h0000_7FFF);
            1: v = 32'h9000_8000 | (v & 32'h0000_7FFF);
            default: v = 32'h3000_0000 | (v & 32'h0000_7FFF);
         endcase
      end
      return v;
   endfunction

   task automatic drive_cycle(input bit allow_req);
      lsu_pkt_t    p;
      lsu_flush_t  f;
      lsu_cfg_wr_t w;
      model_req_t  e;
      logic [31:0] rs1;
      logic [31:0] daddr;
      logic [31:0] rs2;
      logic [63:0] wdata;
      logic [11:0] off;
      logic [1:0]  sz;
      logic        ld;
      logic        uns;
      logic        is_dma;
      logic        core_v;
      w      = '0;
      is_dma = 1'b0;
      core_v = 1'b0;
      if (allow_req && ($urandom % 100) < 3) begin
         // Config write on an idle cycle
         w.valid = 1'b1;
         w.sel   = 2'($urandom % 3);
         w.data  = pick_config_data(w.sel);
         apply_config_write(w.sel, w.data);
      end else if (allow_req) begin
         is_dma = ($urandom % 10) == 0;
         core_v = ($urandom % 4) != 0;
      end
      sz       = 2'($urandom);
      ld       = 1'($urandom);
      uns      = 1'($urandom);
      rs1      = pick_address();
      daddr    = pick_address();
      rs2      = $urandom;
      wdata    = {$urandom, $urandom};
      off      = (($urandom % 2) == 0) ? 12'h000 : 12'($urandom);
      f.dc2_up = ($urandom % 100) < 5;
      f.dc3    = ($urandom % 100) < 5;
      f.dc4    = ($urandom % 100) < 5;
      f.dc5    = ($urandom % 100) < 5;
      p        = '0;
      p.valid  = core_v;
      p.load   = ld;
      p.store  = ~ld;
      p.unsign = uns;
      p.by     = (sz == 2'd0);
      p.half   = (sz == 2'd1);
      p.word   = (sz == 2'd2);
      p.dword  = (sz == 2'd3);
      // DMA wins over the core request of the same cycle
      if (is_dma) begin
         e = decode_request(1'b1, 1'b1, ld, 1'b0, sz, daddr, 12'h000,
                            wdata >> (8 * daddr[2:0]));
      end else begin
         e = decode_request(core_v, 1'b0, ld, uns, sz, rs1, off, {32'h0, rs2});
      end
      lsu_p            <= p;
      exu_lsu_rs1_d    <= rs1;
      exu_lsu_rs2_d    <= rs2;
      dec_lsu_offset_d <= off;
      dma_dccm_req     <= is_dma;
      dma_mem_addr     <= daddr;
      dma_mem_sz       <= {1'b0, sz};
      dma_mem_write    <= ~ld;
      dma_mem_wdata    <= wdata;
      flush            <= f;
      cfg_wr           <= w;
      cur_flush        = f;
      pipe_q.push_front(e);
      if (pipe_q.size() > 6) begin
         void'(pipe_q.pop_back());
      end
      // Read data for the request now entering DC3
      if (pipe_q.size() > 3) begin
         lsu_ld_data_dc3   <= dccm_hash(pipe_q[3].addr);
         bus_read_data_dc3 <= bus_hash(pipe_q[3].addr);
      end
   endtask

   //************************************************************
   // Checks, sampled at the falling edge
   //************************************************************
   task automatic check_outputs();
      model_req_t  e3;
      model_req_t  e5;
      logic [31:0] raw;
      logic        exp_exc;
      logic        exp_type;
      logic        exp_commit;
      e3 = '0;
      e5 = '0;
      if (pipe_q.size() > 3) begin
         e3 = pipe_q[3];
      end
      if (pipe_q.size() > 5) begin
         e5 = pipe_q[5];
      end
      exp_exc = e3.alive && !e3.dma && (e3.access_fault || e3.misaligned_fault) &&
                !cur_flush.dc3;
      exp_type = ~e3.misaligned_fault;
      if (lsu_pkt_dc3.valid !== e3.alive)
         report_mismatch("lsu_pkt_dc3.valid", 64'(e3.alive), 64'(lsu_pkt_dc3.valid));
      if (lsu_error_pkt_dc3.exc_valid !== exp_exc)
         report_mismatch("exc_valid", 64'(exp_exc), 64'(lsu_error_pkt_dc3.exc_valid));
      if (e3.alive) begin
         if (lsu_pkt_dc3 !== expected_pkt(e3))
            report_mismatch("lsu_pkt_dc3", 64'(expected_pkt(e3)), 64'(lsu_pkt_dc3));
         if (lsu_addr_dc3 !== e3.addr)
            report_mismatch("lsu_addr_dc3", 64'(e3.addr), 64'(lsu_addr_dc3));
         if (lsu_error_pkt_dc3.addr !== e3.addr)
            report_mismatch("lsu_error_pkt_dc3.addr", 64'(e3.addr),
                            64'(lsu_error_pkt_dc3.addr));
         if (lsu_error_pkt_dc3.dma_valid !== e3.dma)
            report_mismatch("dma_valid", 64'(e3.dma), 64'(lsu_error_pkt_dc3.dma_valid));
         if (exp_exc && lsu_error_pkt_dc3.exc_type !== exp_type)
            report_mismatch("exc_type", 64'(exp_type), 64'(lsu_error_pkt_dc3.exc_type));
         if (exp_exc && lsu_error_pkt_dc3.inst_type !== e3.store)
            report_mismatch("inst_type", 64'(e3.store), 64'(lsu_error_pkt_dc3.inst_type));
         raw = e3.external ? bus_hash(e3.addr) : dccm_hash(e3.addr);
         if (e3.load && lsu_result_dc3 !== format_load(raw, e3.size, e3.unsign))
            report_mismatch("lsu_result_dc3", 64'(format_load(raw, e3.size, e3.unsign)),
                            64'(lsu_result_dc3));
      end
      exp_commit = e5.alive && !e5.dma && !cur_flush.dc5;
      if (lsu_pkt_dc5.valid !== e5.alive)
         report_mismatch("lsu_pkt_dc5.valid", 64'(e5.alive), 64'(lsu_pkt_dc5.valid));
      if (lsu_commit_dc5 !== exp_commit)
         report_mismatch("lsu_commit_dc5", 64'(exp_commit), 64'(lsu_commit_dc5));
      if (e5.alive) begin
         if (lsu_pkt_dc5 !== expected_pkt(e5))
            report_mismatch("lsu_pkt_dc5", 64'(expected_pkt(e5)), 64'(lsu_pkt_dc5));
         if (lsu_addr_dc5 !== e5.addr)
            report_mismatch("lsu_addr_dc5", 64'(e5.addr), 64'(lsu_addr_dc5));
         if (addr_external_dc5 !== e5.external)
            report_mismatch("addr_external_dc5", 64'(e5.external), 64'(addr_external_dc5));
         if (store_data_dc5 !== e5.store_data[31:0])
            report_mismatch("store_data_dc5", 64'(e5.store_data[31:0]), 64'(store_data_dc5));
      end
   endtask

   initial begin
      void'($urandom(70790));
      errors            = 0;
      cur_flush         = '0;
      reset_model();
      rst               = 1'b1;
      exu_lsu_rs1_d     = '0;
      exu_lsu_rs2_d     = '0;
      dec_lsu_offset_d  = '0;
      lsu_p             = '0;
      dma_dccm_req      = 1'b0;
      dma_mem_addr      = '0;
      dma_mem_sz        = '0;
      dma_mem_write     = 1'b0;
      dma_mem_wdata     = '0;
      flush             = '0;
      cfg_wr            = '0;
      lsu_ld_data_dc3   = '0;
      bus_read_data_dc3 = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      for (int cyc = 0; cyc < 3000; cyc++) begin
         @(posedge clk);
         drive_cycle(1'b1);
         @(negedge clk);
         check_outputs();
         apply_flush();
      end
      // Idle until the last live request has left DC5
      waited = 0;
      while ((alive_count() != 0 || lsu_pkt_dc3.valid !== 1'b0 ||
              lsu_pkt_dc5.valid !== 1'b0) && waited < 20) begin
         @(posedge clk);
         drive_cycle(1'b0);
         @(negedge clk);
         check_outputs();
         apply_flush();
         waited++;
      end
      if (alive_count() != 0 || lsu_pkt_dc3.valid !== 1'b0 ||
          lsu_pkt_dc5.valid !== 1'b0) begin
         $display("Pipeline still holds valid requests after 20 idle cycles");
         errors++;
      end
      $display("Summary: %0d error(s) over 3000 traffic cycles", errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+tests
design/lsu_pkg.sv
design/lsu_region_cfg.sv
design/lsu_req_mux.sv
design/lsu_addr_check.sv
design/lsu_pipe_stage.sv
design/lsu_dc_pipe.sv
design/lsu_load_format.sv
design/lsu_ctl_top.sv
tests/tb_lsu_top.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_lsu_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
